// ==== verilog/i2s_pkg.sv ====
package i2s_pkg;

    // Default data bits carried per channel
    parameter int SAMPLE_WIDTH = 8;

    // Default bit periods per channel slot, at least SAMPLE_WIDTH + 1
    parameter int SLOT_WIDTH = 16;

    typedef logic [SAMPLE_WIDTH-1:0] sample_t;                 // One channel PCM word

    // Slot counter must reach SLOT_WIDTH + 1 (the MSB reload count)
    typedef logic [$clog2(SLOT_WIDTH + 2)-1:0] slot_count_t;

    typedef struct packed {
        sample_t left;                                          // Sent while word_select is 0
        sample_t right;                                         // Sent while word_select is 1
    } stereo_sample_t;

    // Serializer phases, decoded from the slot counter
    typedef enum logic [2:0] {
        IDLE_BIT,                                               // Count 0, dead bit after reset
        LOAD_MSB,                                               // Count 1 or slot+1, MSB out
        SHIFT_DATA,                                             // Remaining data bits
        PAD_ZERO,                                               // Zero fill up to slot end
        WS_TOGGLE                                               // Last bit period of the slot
    } ser_state_t;

endpackage

// ==== verilog/i2s_bit_clock_gen.sv ====
`timescale 1ns/1ps

module i2s_bit_clock_gen #(
    parameter int clk_div = 4                                   // clk cycles per bit_clk period
) (
    input  logic clk,
    input  logic rst,
    output logic bit_clk,
    output logic bit_clk_fall
);

    // Half period in clk cycles, bit_clk toggles once per half
    localparam int half_period = clk_div / 2;
    localparam int div_width = (half_period > 1) ? $clog2(half_period) : 1;
    localparam logic [div_width-1:0] div_last = div_width'(half_period - 1);

    logic [div_width-1:0] div_cnt;                              // Position inside the half period
    logic                 div_wrap;                             // Last cycle of a half period

    assign div_wrap = (div_cnt == div_last);

    // Divide counter, free running from reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (div_wrap) begin
            div_cnt <= '0;                                      // Start next half period
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Bit clock register, low out of reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_clk <= 1'b0;
        end else if (div_wrap) begin
            bit_clk <= ~bit_clk;                                // Toggle at every wrap
        end
    end

    // High in the cycle where bit_clk is about to be loaded with 0,
    // so logic using it updates on the same clk edge as the falling edge
    assign bit_clk_fall = div_wrap & bit_clk;

endmodule

// ==== verilog/sample_frame_buffer.sv ====
`timescale 1ns/1ps

module sample_frame_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  i2s_pkg::stereo_sample_t sample_in,
    input  logic                   sample_valid,
    input  logic                   frame_request,
    output i2s_pkg::stereo_sample_t active_sample
);

    import i2s_pkg::*;

    // Writer side stage, latest pair from the source
    stereo_sample_t pending_sample;

    // Pending stage takes every valid pair, a newer one overwrites an unsent one
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending_sample <= '0;                               // Silence until first write
        end else if (sample_valid) begin
            pending_sample <= sample_in;
        end
    end

    // Active stage only moves at a frame boundary,
    // so left and right of one frame always come from the same pair
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_sample <= '0;
        end else if (frame_request) begin
            active_sample <= pending_sample;                    // Held for the whole frame
        end
    end

endmodule

// ==== verilog/i2s_serializer.sv ====
`timescale 1ns/1ps

module i2s_serializer #(
    parameter int slot_width = i2s_pkg::SLOT_WIDTH              // Bit periods per channel slot
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   bit_clk_fall,
    input  i2s_pkg::stereo_sample_t active_sample,
    output logic                   serial_out,
    output logic                   word_select,
    output logic                   frame_request
);

    import i2s_pkg::*;

    // Slot counter landmarks
    localparam slot_count_t cnt_msb        = slot_count_t'(1);             // First MSB after reset
    localparam slot_count_t cnt_first_shift = slot_count_t'(2);            // After any MSB
    localparam slot_count_t cnt_last_data  = slot_count_t'(SAMPLE_WIDTH);  // Final data bit
    localparam slot_count_t cnt_toggle     = slot_count_t'(slot_width);    // Slot end
    localparam slot_count_t cnt_msb_next   = slot_count_t'(slot_width + 1); // MSB of later slots

    slot_count_t slot_cnt;                                      // Bit period inside the slot
    slot_count_t slot_cnt_n;
    ser_state_t  state;                                         // Decoded phase of slot_cnt
    sample_t     shift_reg;                                     // Remaining bits of the channel
    sample_t     shift_n;
    sample_t     cur_chan;                                      // Channel chosen by word_select
    logic        serial_out_n;
    logic        word_select_n;
    logic        frame_request_n;

    // Phase decode, counter ranges follow the slot layout
    always_comb begin
        if (slot_cnt == '0) begin
            state = IDLE_BIT;
        end else if (slot_cnt == cnt_msb || slot_cnt == cnt_msb_next) begin
            state = LOAD_MSB;
        end else if (slot_cnt <= cnt_last_data) begin
            state = SHIFT_DATA;
        end else if (slot_cnt < cnt_toggle) begin
            state = PAD_ZERO;
        end else begin
            state = WS_TOGGLE;
        end
    end

    // word_select already holds its new value when a load happens,
    // it was toggled one bit period earlier
    assign cur_chan = word_select ? active_sample.right : active_sample.left;

    // Next state, only advances on a bit_clk falling edge
    always_comb begin
        slot_cnt_n      = slot_cnt;
        serial_out_n    = serial_out;
        word_select_n   = word_select;
        shift_n         = shift_reg;
        frame_request_n = 1'b0;                                 // Pulse, one cycle only
        if (bit_clk_fall) begin
            case (state)
                IDLE_BIT: begin
                    serial_out_n    = 1'b0;                     // Dead bit
                    frame_request_n = 1'b1;                     // Fetch first stereo pair
                    slot_cnt_n      = cnt_msb;
                end
                LOAD_MSB: begin
                    serial_out_n = cur_chan[SAMPLE_WIDTH-1];    // Straight from the input
                    shift_n      = {cur_chan[SAMPLE_WIDTH-2:0], 1'b0};
                    slot_cnt_n   = cnt_first_shift;
                end
                SHIFT_DATA: begin
                    serial_out_n = shift_reg[SAMPLE_WIDTH-1];
                    shift_n      = {shift_reg[SAMPLE_WIDTH-2:0], 1'b0};
                    slot_cnt_n   = slot_cnt + 1'b1;
                end
                PAD_ZERO: begin
                    serial_out_n = 1'b0;                        // Unused slot bits
                    slot_cnt_n   = slot_cnt + 1'b1;
                end
                WS_TOGGLE: begin
                    serial_out_n    = 1'b0;
                    word_select_n   = ~word_select;             // One bit ahead of the MSB
                    frame_request_n = word_select;              // Right slot done, left is next
                    slot_cnt_n      = cnt_msb_next;
                end
                default: begin
                    slot_cnt_n = '0;                            // Restart with a dead bit
                end
            endcase
        end
    end

    // Control and output registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_cnt      <= '0;
            serial_out    <= 1'b0;
            word_select   <= 1'b0;                              // Left channel first
            frame_request <= 1'b0;
        end else begin
            slot_cnt      <= slot_cnt_n;
            serial_out    <= serial_out_n;
            word_select   <= word_select_n;
            frame_request <= frame_request_n;
        end
    end

    // Data shift register, MSB leaves first
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shift_reg <= '0;
        end else begin
            shift_reg <= shift_n;
        end
    end

endmodule

// ==== verilog/i2s_audio_tx.sv ====
`timescale 1ns/1ps

module i2s_audio_tx #(
    parameter int clk_div    = 4,                               // clk cycles per bit period
    parameter int slot_width = i2s_pkg::SLOT_WIDTH              // Bit periods per channel slot
) (
    input  logic                   clk,
    input  logic                   rst,
    input  i2s_pkg::stereo_sample_t sample_in,
    input  logic                   sample_valid,
    output logic                   bit_clk,
    output logic                   word_select,
    output logic                   serial_out
);

    import i2s_pkg::*;

    logic           bit_clk_fall;                               // One cycle per falling edge
    logic           frame_request;                              // Start of every left slot
    stereo_sample_t active_sample;                              // Pair being sent this frame

    // Serial bit clock and its falling edge strobe
    i2s_bit_clock_gen #(
        .clk_div      (clk_div)
    ) i_bit_clock_gen (
        .clk          (clk),
        .rst          (rst),
        .bit_clk      (bit_clk),
        .bit_clk_fall (bit_clk_fall)
    );

    // Pending and active stereo registers
    sample_frame_buffer i_frame_buffer (
        .clk           (clk),
        .rst           (rst),
        .sample_in     (sample_in),
        .sample_valid  (sample_valid),
        .frame_request (frame_request),
        .active_sample (active_sample)
    );

    // Slot counting and MSB first shifting
    i2s_serializer #(
        .slot_width    (slot_width)
    ) i_serializer (
        .clk           (clk),
        .rst           (rst),
        .bit_clk_fall  (bit_clk_fall),
        .active_sample (active_sample),
        .serial_out    (serial_out),
        .word_select   (word_select),
        .frame_request (frame_request)
    );

endmodule

// ==== verification/i2s_rx_monitor.sv ====
`timescale 1ns/1ps

module i2s_rx_monitor #(
    parameter int slot_width = i2s_pkg::SLOT_WIDTH              // Bit periods per channel slot
) (
    input  logic             rst,
    input  logic             bit_clk,
    input  logic             word_select,
    input  logic             serial_out,
    output i2s_pkg::sample_t rx_word,                           // Last complete channel word
    output logic             rx_right,                          // Channel of rx_word
    output logic             rx_pad_ok,                         // No 1 outside the data bits
    output int               rx_count                           // Steps once per word
);

    import i2s_pkg::*;

    logic    prev_ws;                                           // word_select one period ago
    logic    synced;                                            // First ws change seen
    int      bit_idx;                                           // Period inside the ws window
    sample_t word_acc;                                          // Data bits, MSB first
    logic    pad_clean;

    // Receiver samples in the middle of each bit period
    always @(posedge bit_clk or posedge rst) begin
        if (rst) begin
            prev_ws   = 1'b0;
            synced    = 1'b0;
            bit_idx   = 0;
            word_acc  = '0;
            pad_clean = 1'b1;
            rx_word   <= '0;
            rx_right  <= 1'b0;
            rx_pad_ok <= 1'b1;
            rx_count  <= 0;
        end else begin
            if (word_select != prev_ws) begin
                synced    = 1'b1;                               // Window opens, MSB comes next
                bit_idx   = 0;
                pad_clean = 1'b1;
            end else begin
                bit_idx = bit_idx + 1;
            end
            prev_ws = word_select;
            if (bit_idx >= 1 && bit_idx <= SAMPLE_WIDTH) begin
                word_acc = {word_acc[SAMPLE_WIDTH-2:0], serial_out};
            end else if (serial_out) begin
                pad_clean = 1'b0;                               // Stray 1 in toggle or pad bits
            end
            if (synced && bit_idx == slot_width - 1) begin      // Last period of the slot
                rx_word   <= word_acc;
                rx_right  <= word_select;
                rx_pad_ok <= pad_clean;
                rx_count  <= rx_count + 1;
            end
        end
    end

endmodule

// ==== verification/tb_i2s_audio_tx.sv ====
`timescale 1ns/1ps

module tb_i2s_audio_tx;

    import i2s_pkg::*;

    localparam int clk_div      = 4;
    localparam int slot_width   = SLOT_WIDTH;
    localparam int clk_period   = 40;                           // ns
    localparam int slot_cycles  = slot_width * clk_div;         // clk cycles per slot
    localparam int frame_cycles = 2 * slot_cycles;
    localparam int first_toggle = clk_div + slot_cycles;        // First word_select change
    localparam int msb_first    = 2 * clk_div;                  // Left MSB after the dead bit
    localparam int last_frame   = 14;
    localparam int n_frames     = last_frame + 1;
    localparam int bit_period   = clk_div * clk_period;
    localparam int timeout_ns   = (n_frames + 2) * 2 * slot_width * bit_period
                                  + 10 * clk_period;

    bit             clk;                                        // Starts low, no edge at time 0
    logic           rst;
    stereo_sample_t sample_in;
    logic           sample_valid;
    logic           bit_clk;
    logic           word_select;
    logic           serial_out;

    sample_t        rx_word;
    logic           rx_right;
    logic           rx_pad_ok;
    int             rx_count;

    stereo_sample_t exp_q[$];                                   // One entry per frame
    stereo_sample_t last_written;                               // Newest pair driven
    integer         seed;
    int             cyc;                                        // clk edges since reset release
    int             err_count;
    int             checks_run;
    int             words_checked;
    int             test_err_start;
    int             tests_passed;
    int             tests_failed;

    i2s_audio_tx #(
        .clk_div      (clk_div),
        .slot_width   (slot_width)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .bit_clk      (bit_clk),
        .word_select  (word_select),
        .serial_out   (serial_out)
    );

    i2s_rx_monitor #(
        .slot_width  (slot_width)
    ) i_rx_monitor (
        .rst         (rst),
        .bit_clk     (bit_clk),
        .word_select (word_select),
        .serial_out  (serial_out),
        .rx_word     (rx_word),
        .rx_right    (rx_right),
        .rx_pad_ok   (rx_pad_ok),
        .rx_count    (rx_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic int frame_start(input int n);
        return clk_div + n * frame_cycles;                      // Edge of fall 32n, frame_request
    endfunction

    function automatic stereo_sample_t make_pair(input sample_t l, input sample_t r);
        stereo_sample_t p;
        p.left  = l;
        p.right = r;
        return p;
    endfunction

    task expect_bit(input string name, input logic expected, input logic actual);
        checks_run++;
        assert (actual === expected) else begin
            $display("error at %0t: %s expected %b actual %b", $time, name, expected, actual);
            err_count++;
        end
    endtask

    task expect_word(input string name, input sample_t expected, input sample_t actual);
        checks_run++;
        assert (actual === expected) else begin
            $display("error at %0t: %s expected %h actual %h", $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic wait_cycle(input int at_cycle);
        while (cyc < at_cycle) begin
            @(posedge clk);
            #5;                                                 // Drive point after the edge
        end
    endtask

    task automatic write_pair_at(input int at_cycle, input stereo_sample_t pair);
        wait_cycle(at_cycle);
        sample_in    = pair;
        sample_valid = 1'b1;
        last_written = pair;                                    // Taken at the next edge
        @(posedge clk);
        #5;
        sample_valid = 1'b0;
    endtask

    task start_test();
        test_err_start = err_count;
    endtask

    task finish_test(input string name);
        if (err_count == test_err_start) begin
            tests_passed++;
            $display("test %s: pass at %0t", name, $time);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", name, err_count - test_err_start);
        end
    endtask

    // Cycle count and frame boundary prediction from the counting rule
    always @(posedge clk) begin
        if (rst) begin
            cyc = 0;
        end else begin
            cyc = cyc + 1;
            if (cyc >= clk_div && (cyc - clk_div) % frame_cycles == 0) begin
                exp_q.push_back(last_written);                  // Pair latched for this frame
            end
        end
    end

    // Per-cycle waveform checks, sampled away from the active edge
    always @(negedge clk) begin : cycle_checks
        int             toggles;
        logic           ws_exp;
        logic           msb_exp;
        stereo_sample_t cur_pair;
        expect_bit("bit_clk", (cyc % clk_div) >= (clk_div / 2), bit_clk);
        if (cyc >= first_toggle) begin
            toggles = (cyc - clk_div) / slot_cycles;
        end else begin
            toggles = 0;
        end
        ws_exp = (toggles % 2) == 1;                            // Left first, then alternating
        expect_bit("word_select", ws_exp, word_select);
        if (rst || cyc < msb_first) begin
            expect_bit("serial_out", 1'b0, serial_out);         // Quiet until the first MSB
        end else if ((cyc - msb_first) % slot_cycles == 0 && exp_q.size() > 0) begin
            cur_pair = exp_q[$];                                // MSB one period after a toggle
            msb_exp  = ws_exp ? cur_pair.right[SAMPLE_WIDTH-1] : cur_pair.left[SAMPLE_WIDTH-1];
            expect_bit("serial_out", msb_exp, serial_out);
        end
    end

    // Words from the receiver against the expected frame queue
    initial begin : word_checks
        logic           expect_right;
        stereo_sample_t exp_pair;
        sample_t        exp_word;
        string          name;
        expect_right = 1'b1;                                    // First full window is right
        forever begin
            @(rx_count);
            #1;
            if (rx_right) begin
                name = "right word";
            end else begin
                name = "left word";
            end
            if (exp_q.size() == 0) begin
                $display("a %s arrived at %0t with no expected pair queued", name, $time);
                err_count++;
            end else begin
                exp_pair = exp_q[0];
                exp_word = rx_right ? exp_pair.right : exp_pair.left;
                expect_bit("rx channel", expect_right, rx_right);
                expect_word(name, exp_word, rx_word);
                checks_run++;
                assert (rx_pad_ok) else begin
                    $display("the %s slot ending at %0t carried a 1 outside its data", name,
                             $time);
                    err_count++;
                end
                if (rx_right) begin
                    exp_q.pop_front();                          // Frame complete
                end
            end
            expect_right  = ~expect_right;
            words_checked++;
        end
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("simulation still running after %0d ns, stopped by the watchdog", timeout_ns);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main_sequence
        int rnd;
        rst            = 1'b1;
        sample_in      = '0;
        sample_valid   = 1'b0;
        last_written   = '0;                                    // Matches the pending reset value
        seed           = 79581;
        cyc            = 0;
        err_count      = 0;
        checks_run     = 0;
        words_checked  = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        test_err_start = 0;
        start_test();                                           // Covers the reset window too
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;

        wait_cycle(2);
        finish_test("reset values");

        start_test();                                           // Outputs free running, silence
        wait_cycle(frame_start(2));
        finish_test("bit clock divide");

        start_test();
        for (int n = 2; n <= 7; n++) begin
            rnd = $random(seed);
            write_pair_at(frame_start(n) + 3 * slot_cycles / 2,
                          stereo_sample_t'(rnd[2*SAMPLE_WIDTH-1:0])); // Mid right slot
        end
        wait_cycle(frame_start(9) + 8);
        finish_test("random stereo frames");

        start_test();                                           // Edge patterns for MSB position
        write_pair_at(frame_start(9) + 96, make_pair('1, sample_t'(1)));
        write_pair_at(frame_start(10) + 96,
                      make_pair(sample_t'(1), sample_t'(1) << (SAMPLE_WIDTH - 1)));
        write_pair_at(frame_start(11) + 96, make_pair(sample_t'(1) << (SAMPLE_WIDTH - 1), '1));
        wait_cycle(frame_start(12) + 8);
        finish_test("word select alignment");

        start_test();
        rnd = $random(seed);
        write_pair_at(frame_start(12) + 20, stereo_sample_t'(rnd[2*SAMPLE_WIDTH-1:0]));
        rnd = $random(seed);
        write_pair_at(frame_start(12) + 100, stereo_sample_t'(rnd[2*SAMPLE_WIDTH-1:0]));
        rnd = $random(seed);
        write_pair_at(frame_start(13) + 20, stereo_sample_t'(rnd[2*SAMPLE_WIDTH-1:0]));
        wait_cycle(frame_start(last_frame) + frame_cycles + 2);
        checks_run++;
        assert (words_checked == 2 * last_frame + 1) else begin
            $display("the receiver delivered %0d words where %0d were due", words_checked,
                     2 * last_frame + 1);
            err_count++;
        end
        finish_test("mid-frame update");

        $display("summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, checks_run, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== i2s_audio_tx.f ====
verilog/i2s_pkg.sv
verilog/i2s_bit_clock_gen.sv
verilog/sample_frame_buffer.sv
verilog/i2s_serializer.sv
verilog/i2s_audio_tx.sv
verification/i2s_rx_monitor.sv
verification/tb_i2s_audio_tx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the I2S transmitter testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_i2s_audio_tx \
    --Mdir obj_dir \
    -f i2s_audio_tx.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_i2s_audio_tx)
status=$?
echo "$sim_out"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The testbench prints its verdict on a line of its own
if echo "$sim_out" | grep -qx "TEST PASSED"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi
